/* ifetch_settings.svh */
`ifndef IFETCH_SETTINGS_SVH
`define IFETCH_SETTINGS_SVH

// cache geometry
`define IF_SETS        8
`define IF_WAYS        2
`define IF_LINE_WORDS  4

// output buffer and fetch id
`define IF_FIFO_DEPTH  4
`define IF_ID_W        4

// legal fetch window
`define IF_MEM_BASE    32'h0000_1000
`define IF_MEM_SIZE    32'h0000_1000

// derived widths
`define IF_SET_W       $clog2(`IF_SETS)
`define IF_WAY_W       $clog2(`IF_WAYS)
`define IF_WORD_W      $clog2(`IF_LINE_WORDS)
`define IF_TAG_W       (32 - `IF_SET_W - `IF_WORD_W - 2)

`endif

/* ifetchPkg.sv */
`include "ifetch_settings.svh"

package ifetchPkg;

    typedef logic [`IF_ID_W-1:0] fetchId_t;

    // one line of instruction words
    typedef logic [`IF_LINE_WORDS-1:0][31:0] line_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } fetchReq_t;

    // valid travels on the stream beside it
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
        fetchId_t    fetchId;
        logic        fault;
    } fetchPacket_t;

    typedef struct packed {
        logic        valid;
        fetchId_t    fetchId;
        logic [31:0] pc;
    } fetchRedirect_t;

    // next id issued is fetchId + 1
    typedef struct packed {
        logic     valid;
        fetchId_t fetchId;
    } clearReq_t;

    typedef struct packed {
        logic                 valid;
        logic [`IF_TAG_W-1:0] tag;
    } tagEntry_t;

    typedef struct packed {
        logic                 en;
        logic [`IF_SET_W-1:0] set;
    } arrayRead_t;

    typedef struct packed {
        logic                  dataEn;
        logic                  tagEn;
        logic [`IF_WAY_W-1:0]  way;
        logic [`IF_SET_W-1:0]  set;
        logic [`IF_WORD_W-1:0] word;
        logic [31:0]           data;
        tagEntry_t             tag;
    } arrayWrite_t;

    typedef struct packed {
        logic                 valid;
        logic [31:0]          lineAddr;
        logic [`IF_SET_W-1:0] set;
    } refillReq_t;

    typedef struct packed {
        logic        arvalid;
        logic [31:0] araddr;
        logic [2:0]  arprot;
    } axiAr_t;

    typedef struct packed {
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axiR_t;

endpackage

/* icacheArrays.sv */
`include "ifetch_settings.svh"

module icacheArrays (
    input  logic                                  clk,
    input  logic                                  rst,
    input  ifetchPkg::arrayRead_t                 rdReq,
    output ifetchPkg::tagEntry_t [`IF_WAYS-1:0]   tags,
    output ifetchPkg::line_t [`IF_WAYS-1:0]       lines,
    input  ifetchPkg::arrayWrite_t                wr
);

    logic [`IF_WAYS-1:0][`IF_SETS-1:0] validBits;
    logic [`IF_TAG_W-1:0] tagMem [`IF_WAYS][`IF_SETS];
    logic [31:0] dataMem [`IF_WAYS][`IF_SETS][`IF_LINE_WORDS];

    // valid bits start cleared, the flush walk clears them again anyway
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            validBits <= '0;
        end else if (wr.tagEn) begin
            validBits[wr.way][wr.set] <= wr.tag.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wr.tagEn) begin
            tagMem[wr.way][wr.set] <= wr.tag.tag;
        end
        if (wr.dataEn) begin
            dataMem[wr.way][wr.set][wr.word] <= wr.data;
        end
    end

    // all ways read together, result held until the next read
    always_ff @(posedge clk) begin
        if (rdReq.en) begin
            for (int w = 0; w < `IF_WAYS; w++) begin
                tags[w].valid <= validBits[w][rdReq.set];
                tags[w].tag <= tagMem[w][rdReq.set];
                for (int i = 0; i < `IF_LINE_WORDS; i++) begin
                    lines[w][i] <= dataMem[w][rdReq.set][i];
                end
            end
        end
    end

endmodule

/* icacheRefill.sv */
`include "ifetch_settings.svh"

module icacheRefill (
    input  logic                   clk,
    input  logic                   rst,
    input  ifetchPkg::refillReq_t  req,
    output logic                   busy,
    output ifetchPkg::arrayWrite_t wr,
    output ifetchPkg::axiAr_t      ar,
    input  logic                   arready,
    input  ifetchPkg::axiR_t       r,
    output logic                   rready
);

    localparam int WAY_W = `IF_WAY_W;
    localparam int WORD_W = `IF_WORD_W;
    localparam int OFFS_W = WORD_W + 2;

    typedef enum logic [1:0] {
        RF_IDLE,
        RF_ADDR,
        RF_DATA,
        RF_TAG
    } state_t;

    state_t state;
    logic [WAY_W-1:0] rrWay;
    logic [WORD_W-1:0] wordIdx;
    logic sawError;
    logic [31:0] lineAddr;
    logic [`IF_SET_W-1:0] set;
    logic [WAY_W-1:0] way;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= RF_IDLE;
            rrWay <= '0;
            wordIdx <= '0;
            sawError <= 1'b0;
        end else begin
            case (state)
                RF_IDLE: begin
                    if (req.valid) begin
                        state <= RF_ADDR;
                        wordIdx <= '0;
                        sawError <= 1'b0;
                        rrWay <= (rrWay == WAY_W'(`IF_WAYS - 1)) ? '0 : rrWay + 1'b1;
                    end
                end
                RF_ADDR: begin
                    if (arready) begin
                        state <= RF_DATA;
                    end
                end
                RF_DATA: begin
                    if (r.rvalid) begin
                        // any error keeps the line invalid
                        sawError <= sawError | (r.rresp != 2'b00);
                        if (wordIdx == WORD_W'(`IF_LINE_WORDS - 1)) begin
                            state <= RF_TAG;
                        end else begin
                            wordIdx <= wordIdx + 1'b1;
                            state <= RF_ADDR;
                        end
                    end
                end
                default: begin
                    state <= RF_IDLE;
                end
            endcase
        end
    end

    // line being loaded
    always_ff @(posedge clk) begin
        if (state == RF_IDLE && req.valid) begin
            lineAddr <= req.lineAddr;
            set <= req.set;
            way <= rrWay;
        end
    end

    always_comb begin
        busy = state != RF_IDLE;
        ar.arvalid = state == RF_ADDR;
        ar.araddr = {lineAddr[31:OFFS_W], wordIdx, 2'b00};
        // instruction access
        ar.arprot = 3'b100;
        rready = state == RF_DATA;

        wr.dataEn = state == RF_DATA && r.rvalid;
        wr.tagEn = state == RF_TAG;
        wr.way = way;
        wr.set = set;
        wr.word = wordIdx;
        wr.data = r.rdata;
        wr.tag.valid = !sawError;
        wr.tag.tag = lineAddr[31 -: `IF_TAG_W];
    end

    arStable: assert property (@(posedge clk) disable iff (rst)
        ar.arvalid && !arready |=> ar.arvalid && $stable(ar.araddr) && $stable(ar.arprot))
        else $error("AR channel changed before arready");

    noReqWhileBusy: assert property (@(posedge clk) disable iff (rst)
        req.valid |-> !busy)
        else $error("refill request while refill busy");

endmodule

/* fetchFifo.sv */
`include "ifetch_settings.svh"

module fetchFifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH = `IF_FIFO_DEPTH
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       clear,
    input  logic                       inValid,
    input  payload_t                   inData,
    output logic [$clog2(DEPTH+1)-1:0] free,
    output logic                       outValid,
    output payload_t                   outData,
    input  logic                       outReady
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W-1:0] wrPtr;
    logic [CNT_W-1:0] count;
    logic push;
    logic pop;

    assign push = inValid && !clear;
    assign pop = outValid && outReady && !clear;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else if (clear) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= inData;
        end
    end

    assign outValid = count != '0;
    assign outData = mem[rdPtr];
    assign free = CNT_W'(DEPTH) - count;

    noPushWhenFull: assert property (@(posedge clk) disable iff (rst)
        push |-> count < CNT_W'(DEPTH))
        else $error("push into full output FIFO");

endmodule

/* ifetchPipeline.sv */
`include "ifetch_settings.svh"

module ifetchPipeline (
    input  logic                                  clk,
    input  logic                                  rst,
    input  ifetchPkg::fetchReq_t                  fetchReq,
    output logic                                  reqReady,
    input  ifetchPkg::clearReq_t                  clear,
    input  logic                                  clearCache,
    output ifetchPkg::fetchRedirect_t             redirect,
    output ifetchPkg::fetchPacket_t               outPacket,
    output logic                                  outValid,
    input  logic                                  outReady,
    output ifetchPkg::arrayRead_t                 rdReq,
    input  ifetchPkg::tagEntry_t [`IF_WAYS-1:0]   tags,
    input  ifetchPkg::line_t [`IF_WAYS-1:0]       lines,
    output ifetchPkg::arrayWrite_t                flushWrite,
    output ifetchPkg::refillReq_t                 refill,
    input  logic                                  refillBusy
);

    localparam int FREE_W = $clog2(`IF_FIFO_DEPTH + 1);
    localparam int WAY_W = `IF_WAY_W;
    localparam int SET_W = `IF_SET_W;
    localparam int OFFS_W = `IF_WORD_W + 2;
    localparam int FLUSH_W = WAY_W + SET_W;

    typedef struct packed {
        logic                valid;
        logic [31:0]         pc;
        ifetchPkg::fetchId_t fetchId;
    } stage_t;

    typedef enum logic [1:0] {
        FLUSH_IDLE,
        FLUSH_QUEUED,
        FLUSH_ACTIVE,
        FLUSH_FINALIZE
    } flushState_t;

    stage_t s0;
    stage_t s1;
    ifetchPkg::fetchId_t idCnt;
    flushState_t flushState;
    logic [FLUSH_W-1:0] flushIdx;
    logic [FREE_W-1:0] fifoFree;
    logic accept;
    logic legal;
    logic hit;
    logic miss;
    logic pushValid;
    logic [`IF_WAYS-1:0] hitVec;
    logic [WAY_W-1:0] hitWay;
    ifetchPkg::fetchPacket_t packet;

    // room for the new request plus everything already in flight
    always_comb begin
        reqReady = flushState == FLUSH_IDLE && !refillBusy && !miss && !clear.valid
            && (int'(fifoFree) - int'(s0.valid) - int'(s1.valid) >= 1);
    end
    assign accept = fetchReq.valid && reqReady;

    // stage 0 reads the arrays, data is there in stage 1
    assign rdReq = '{en: s0.valid, set: s0.pc[OFFS_W +: SET_W]};

    always_comb begin
        legal = s1.pc >= `IF_MEM_BASE && s1.pc < (`IF_MEM_BASE + `IF_MEM_SIZE);
        hitWay = '0;
        for (int w = 0; w < `IF_WAYS; w++) begin
            hitVec[w] = tags[w].valid && tags[w].tag == s1.pc[31 -: `IF_TAG_W];
            if (hitVec[w]) begin
                hitWay = WAY_W'(w);
            end
        end
        hit = s1.valid && legal && (|hitVec);
        // a clear in the same cycle wins over a miss
        miss = s1.valid && legal && !(|hitVec) && !clear.valid;
        pushValid = s1.valid && !clear.valid && (!legal || hit);

        packet.pc = s1.pc;
        packet.fetchId = s1.fetchId;
        packet.fault = !legal;
        packet.instr = legal ? lines[hitWay][s1.pc[OFFS_W-1:2]] : 32'h0;
    end

    assign redirect = '{valid: miss, fetchId: s1.fetchId, pc: s1.pc};
    assign refill = '{
        valid: miss,
        lineAddr: {s1.pc[31:OFFS_W], {OFFS_W{1'b0}}},
        set: s1.pc[OFFS_W +: SET_W]
    };

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s0 <= '0;
            s1 <= '0;
            idCnt <= '0;
        end else if (clear.valid) begin
            s0.valid <= 1'b0;
            s1.valid <= 1'b0;
            idCnt <= clear.fetchId + 1'b1;
        end else if (miss) begin
            // younger fetch is dropped, source refetches from the missed pc
            s0.valid <= 1'b0;
            s1.valid <= 1'b0;
            idCnt <= s1.fetchId;
        end else begin
            s1 <= s0;
            s0.valid <= accept;
            if (accept) begin
                s0.pc <= fetchReq.pc;
                s0.fetchId <= idCnt;
                idCnt <= idCnt + 1'b1;
            end
        end
    end

    fetchFifo #(
        .payload_t(ifetchPkg::fetchPacket_t)
    ) u_fifo (
        .clk(clk),
        .rst(rst),
        .clear(clear.valid),
        .inValid(pushValid),
        .inData(packet),
        .free(fifoFree),
        .outValid(outValid),
        .outData(outPacket),
        .outReady(outReady)
    );

    // tag invalidation walk, also run once after reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flushState <= FLUSH_QUEUED;
            flushIdx <= '0;
        end else begin
            case (flushState)
                FLUSH_IDLE: begin
                    flushIdx <= '0;
                    if (clearCache) begin
                        flushState <= FLUSH_QUEUED;
                    end
                end
                FLUSH_QUEUED: begin
                    flushIdx <= '0;
                    if (!s0.valid && !s1.valid && !refillBusy) begin
                        flushState <= FLUSH_ACTIVE;
                    end
                end
                FLUSH_ACTIVE: begin
                    flushIdx <= flushIdx + 1'b1;
                    if (&flushIdx) begin
                        flushState <= FLUSH_FINALIZE;
                    end
                end
                default: begin
                    if (clearCache) begin
                        flushState <= FLUSH_QUEUED;
                    end else if (!refillBusy) begin
                        flushState <= FLUSH_IDLE;
                    end
                end
            endcase
        end
    end

    always_comb begin
        flushWrite = '0;
        flushWrite.tagEn = flushState == FLUSH_ACTIVE;
        flushWrite.way = flushIdx[FLUSH_W-1 -: WAY_W];
        flushWrite.set = flushIdx[SET_W-1:0];
    end

    // a line is never held in two ways of one set
    oneWayHit: assert property (@(posedge clk) disable iff (rst)
        s1.valid |-> $onehot0(hitVec))
        else $error("more than one way hit in stage 1");

endmodule

/* ifetchTop.sv */
`include "ifetch_settings.svh"

module ifetchTop (
    input  logic                      clk,
    input  logic                      rst,
    input  ifetchPkg::fetchReq_t      fetchReq,
    output logic                      reqReady,
    input  ifetchPkg::clearReq_t      clear,
    input  logic                      clearCache,
    output ifetchPkg::fetchRedirect_t redirect,
    output ifetchPkg::fetchPacket_t   outPacket,
    output logic                      outValid,
    input  logic                      outReady,
    output ifetchPkg::axiAr_t         ar,
    input  logic                      arready,
    input  ifetchPkg::axiR_t          r,
    output logic                      rready
);

    ifetchPkg::arrayRead_t rdReq;
    ifetchPkg::tagEntry_t [`IF_WAYS-1:0] tags;
    ifetchPkg::line_t [`IF_WAYS-1:0] lines;
    ifetchPkg::arrayWrite_t flushWrite;
    ifetchPkg::arrayWrite_t refillWrite;
    ifetchPkg::arrayWrite_t arrayWrite;
    ifetchPkg::refillReq_t refillReq;
    logic refillBusy;

    // flush and refill never overlap, busy picks the writer
    assign arrayWrite = refillBusy ? refillWrite : flushWrite;

    ifetchPipeline u_pipeline (
        .clk(clk),
        .rst(rst),
        .fetchReq(fetchReq),
        .reqReady(reqReady),
        .clear(clear),
        .clearCache(clearCache),
        .redirect(redirect),
        .outPacket(outPacket),
        .outValid(outValid),
        .outReady(outReady),
        .rdReq(rdReq),
        .tags(tags),
        .lines(lines),
        .flushWrite(flushWrite),
        .refill(refillReq),
        .refillBusy(refillBusy)
    );

    icacheArrays u_arrays (
        .clk(clk),
        .rst(rst),
        .rdReq(rdReq),
        .tags(tags),
        .lines(lines),
        .wr(arrayWrite)
    );

    icacheRefill u_refill (
        .clk(clk),
        .rst(rst),
        .req(refillReq),
        .busy(refillBusy),
        .wr(refillWrite),
        .ar(ar),
        .arready(arready),
        .r(r),
        .rready(rready)
    );

endmodule

/* tbAxiMem.sv */
`include "ifetch_settings.svh"

module tbAxiMem (
    input  logic              clk,
    input  logic              rst,
    input  ifetchPkg::axiAr_t ar,
    output logic              arready,
    output ifetchPkg::axiR_t  r,
    input  logic              rready
);
    timeunit 1ns;
    timeprecision 1ps;

    logic pending;
    logic [31:0] addr;
    int delay;

    // one read at a time, random gaps before arready and rvalid
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            arready <= 1'b0;
            r <= '0;
            pending <= 1'b0;
            addr <= '0;
            delay <= 0;
        end else begin
            arready <= 1'b0;
            if (!pending) begin
                if (ar.arvalid && !arready) begin
                    if (delay == 0) begin
                        arready <= 1'b1;
                        addr <= ar.araddr;
                        pending <= 1'b1;
                        delay <= int'($urandom_range(3, 0));
                    end else begin
                        delay <= delay - 1;
                    end
                end
            end else if (!r.rvalid) begin
                if (delay == 0) begin
                    r.rvalid <= 1'b1;
                    // beyond the window end the slave answers with an error
                    if (addr >= `IF_MEM_BASE + `IF_MEM_SIZE) begin
                        r.rdata <= 32'h0;
                        r.rresp <= 2'b10;
                    end else begin
                        r.rdata <= addr ^ 32'h5A5A_0000;
                        r.rresp <= 2'b00;
                    end
                end else begin
                    delay <= delay - 1;
                end
            end else if (rready) begin
                r.rvalid <= 1'b0;
                pending <= 1'b0;
                delay <= int'($urandom_range(2, 0));
            end
        end
    end

endmodule

/* tbIfetch.sv */
`include "ifetch_settings.svh"

module tbIfetch;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] MEM_KEY = 32'h5A5A_0000;
    localparam logic [31:0] WALK_END = `IF_MEM_BASE + 32'h80;

    typedef struct packed {
        logic                valid;
        logic [31:0]         pc;
        ifetchPkg::fetchId_t id;
        int                  epoch;
    } modelStage_t;

    logic clk;
    logic rst;
    ifetchPkg::fetchReq_t fetchReq;
    logic reqReady;
    ifetchPkg::clearReq_t clear;
    logic clearCache;
    ifetchPkg::fetchRedirect_t redirect;
    ifetchPkg::fetchPacket_t outPacket;
    logic outValid;
    logic outReady;
    ifetchPkg::axiAr_t ar;
    logic arready;
    ifetchPkg::axiR_t r;
    logic rready;

    int mismatches = 0;
    int failures = 0;
    int nOut = 0;
    int nRefill = 0;

    // reference model of stages, expected output and cached lines
    modelStage_t s0m;
    modelStage_t s1m;
    modelStage_t expQ[$];
    ifetchPkg::fetchId_t modelId;
    ifetchPkg::fetchId_t expOutId;
    ifetchPkg::fetchPacket_t expHead;
    logic expHeadValid;
    logic s1mLegal;
    logic s1mCached;
    logic lineCached [256];
    int lineEpoch [256];
    int epoch;
    logic [31:0] refillLine;
    int arIdx;
    logic refillSeen;

    ifetchTop u_ifetchTop (
        .clk(clk), .rst(rst), .fetchReq(fetchReq), .reqReady(reqReady),
        .clear(clear), .clearCache(clearCache), .redirect(redirect),
        .outPacket(outPacket), .outValid(outValid), .outReady(outReady),
        .ar(ar), .arready(arready), .r(r), .rready(rready)
    );

    tbAxiMem u_mem (
        .clk(clk), .rst(rst), .ar(ar), .arready(arready), .r(r), .rready(rready)
    );

    function automatic logic inWindow(input logic [31:0] pc);
        return pc >= `IF_MEM_BASE && pc < `IF_MEM_BASE + `IF_MEM_SIZE;
    endfunction

    function automatic int lineIndex(input logic [31:0] pc);
        return int'((pc - `IF_MEM_BASE) >> 4) & 255;
    endfunction

    function automatic ifetchPkg::fetchPacket_t expectedPacket(input modelStage_t e);
        ifetchPkg::fetchPacket_t p;
        p.pc = e.pc;
        p.fetchId = e.id;
        p.fault = !inWindow(e.pc);
        p.instr = p.fault ? 32'h0 : e.pc ^ MEM_KEY;
        return p;
    endfunction

    task automatic reportMismatch(input string name, input logic [95:0] exp,
                                  input logic [95:0] act);
        mismatches++;
        $display("mismatch %s expected %h actual %h", name, exp, act);
    endtask

    task automatic reportFailure(input string what);
        failures++;
        $display("error: %s", what);
    endtask

    task automatic finishRun();
        $display("errors: %0d mismatches, %0d other failures, %0d packets, %0d refills",
                 mismatches, failures, nOut, nRefill);
        if (mismatches + failures == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // model update, sampled values are those before the edge
    always @(posedge clk) begin
        if (rst) begin
            s0m = '0;
            s1m = '0;
            expQ.delete();
            modelId = '0;
            expOutId = '0;
            epoch = 0;
            arIdx = 0;
            refillSeen = 1'b0;
            foreach (lineCached[i]) lineCached[i] = 1'b0;
        end else begin
            if (clear.valid) begin
                expQ.delete();
                s0m = '0;
                s1m = '0;
                modelId = clear.fetchId + 1'b1;
                expOutId = clear.fetchId + 1'b1;
            end else begin
                if (outValid && outReady) begin
                    void'(expQ.pop_front());
                    expOutId = expOutId + 1'b1;
                    nOut++;
                end
                if (redirect.valid) begin
                    // missed fetch and the one behind it leave the pipe
                    if (s0m.valid) void'(expQ.pop_back());
                    void'(expQ.pop_back());
                    lineCached[lineIndex(s1m.pc)] = 1'b1;
                    lineEpoch[lineIndex(s1m.pc)] = s1m.epoch;
                    refillLine = {s1m.pc[31:4], 4'h0};
                    arIdx = 0;
                    refillSeen = 1'b1;
                    nRefill++;
                    modelId = s1m.id;
                    s0m = '0;
                    s1m = '0;
                end else begin
                    s1m = s0m;
                    s0m = '0;
                    if (fetchReq.valid && reqReady) begin
                        s0m = '{valid: 1'b1, pc: fetchReq.pc, id: modelId, epoch: epoch};
                        expQ.push_back(s0m);
                        modelId = modelId + 1'b1;
                    end
                end
            end
            if (ar.arvalid && arready) arIdx++;
            if (clearCache) epoch++;
        end
        s1mLegal = inWindow(s1m.pc);
        s1mCached = s1mLegal && lineCached[lineIndex(s1m.pc)]
            && lineEpoch[lineIndex(s1m.pc)] == s1m.epoch;
        expHeadValid = expQ.size() > 0;
        expHead = expHeadValid ? expectedPacket(expQ[0]) : '0;
    end

    instrRule: assert property (@(posedge clk) disable iff (rst)
        outValid && !outPacket.fault |-> outPacket.instr == (outPacket.pc ^ MEM_KEY))
        else reportMismatch("instrRule", 96'($sampled(outPacket.pc) ^ MEM_KEY),
                            96'($sampled(outPacket.instr)));

    idOrder: assert property (@(posedge clk) disable iff (rst)
        outValid && outReady && !clear.valid |-> outPacket.fetchId == expOutId)
        else reportMismatch("idOrder", 96'($sampled(expOutId)),
                            96'($sampled(outPacket.fetchId)));

    redirectId: assert property (@(posedge clk) disable iff (rst)
        redirect.valid |-> s1m.valid && redirect.fetchId == s1m.id && redirect.pc == s1m.pc)
        else reportMismatch("redirectId", 96'({$sampled(s1m.pc), $sampled(s1m.id)}),
                            96'({$sampled(redirect.pc), $sampled(redirect.fetchId)}));

    refillOnce: assert property (@(posedge clk) disable iff (rst)
        redirect.valid |-> !s1mCached)
        else reportFailure("a cached line was refilled again");

    missRefills: assert property (@(posedge clk) disable iff (rst)
        s1m.valid && s1mLegal && !s1mCached && !clear.valid |-> redirect.valid)
        else reportFailure("an uncached line was fetched without a refill");

    arSequence: assert property (@(posedge clk) disable iff (rst)
        ar.arvalid && arready |-> ar.araddr == refillLine + 32'(arIdx * 4)
            && arIdx < `IF_LINE_WORDS)
        else reportMismatch("arSequence", 96'($sampled(refillLine) + 32'($sampled(arIdx) * 4)),
                            96'($sampled(ar.araddr)));

    // instruction fetches carry the instruction access bit
    arInstrProt: assert property (@(posedge clk) disable iff (rst)
        ar.arvalid |-> ar.arprot[2])
        else reportFailure("a read was issued without the instruction access bit in arprot");

    // no new request while a line is loading
    stallDuringRefill: assert property (@(posedge clk) disable iff (rst)
        (ar.arvalid || rready) |-> !reqReady)
        else reportFailure("reqReady was high while a line refill was running");

    lineComplete: assert property (@(posedge clk) disable iff (rst)
        redirect.valid && refillSeen |-> arIdx == `IF_LINE_WORDS)
        else reportMismatch("lineComplete", 96'(`IF_LINE_WORDS), 96'($sampled(arIdx)));

    faultNoAr: assert property (@(posedge clk) disable iff (rst)
        ar.arvalid |-> inWindow(ar.araddr))
        else reportFailure("read issued outside the legal window");

    packetOrder: assert property (@(posedge clk) disable iff (rst)
        outValid && outReady && !clear.valid |-> expHeadValid && outPacket == expHead)
        else reportMismatch("packetOrder", 96'($sampled(expHead)), 96'($sampled(outPacket)));

    initial begin
        logic [31:0] nextPc;
        logic reqIllegal;
        logic stalled;
        int stallCnt;
        int roll;
        int cyc;
        int drainCnt;
        void'($urandom(32'h4437));
        rst = 1'b1;
        fetchReq = '0;
        clear = '0;
        clearCache = 1'b0;
        outReady = 1'b0;
        nextPc = `IF_MEM_BASE;
        reqIllegal = 1'b0;
        stalled = 1'b0;
        stallCnt = 0;
        cyc = 0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        while (cyc < 4000 && !stalled) begin
            @(posedge clk);
            cyc++;
            stallCnt = reqReady ? 0 : stallCnt + 1;
            if (stallCnt > 400) begin
                reportFailure("timeout, reqReady stayed low for 400 cycles");
                stalled = 1'b1;
            end
            if (redirect.valid) begin
                nextPc = redirect.pc;
            end else if (fetchReq.valid && reqReady && !reqIllegal) begin
                nextPc = (nextPc + 4 == WALK_END) ? `IF_MEM_BASE : nextPc + 4;
            end
            roll = int'($urandom_range(99, 0));
            reqIllegal = roll < 4;
            fetchReq <= '{valid: roll < 90,
                          pc: reqIllegal ? (roll[0] ? 32'h0000_0FFC : 32'h0000_2000) : nextPc};
            clear <= '{valid: $urandom_range(99, 0) == 0, fetchId: 4'($urandom)};
            clearCache <= $urandom_range(149, 0) == 0;
            outReady <= $urandom_range(3, 0) != 0;
        end
        fetchReq <= '0;
        clear <= '0;
        clearCache <= 1'b0;
        outReady <= 1'b1;
        drainCnt = 0;
        while (!stalled && (expQ.size() > 0 || outValid)) begin
            @(negedge clk);
            drainCnt++;
            if (drainCnt > 300) begin
                reportFailure("timeout, output did not drain within 300 cycles");
                stalled = 1'b1;
            end
        end
        if (nOut == 0 || nRefill == 0) begin
            reportFailure("no packets or no refills were seen");
        end
        finishRun();
    end

endmodule

/* verilog.f */
+incdir+.
ifetchPkg.sv
icacheArrays.sv
icacheRefill.sv
fetchFifo.sv
ifetchPipeline.sv
ifetchTop.sv
tbAxiMem.sv
tbIfetch.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timing -f verilog.f --top-module tbIfetch -o simIfetch
./obj_dir/simIfetch > sim.log 2>&1
cat sim.log
if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
grep -q "STATUS: PASS" sim.log
